/* all.f */
rtl/nn_pkg.sv
rtl/nn_sample_collector.sv
rtl/nn_weight_bank.sv
rtl/nn_forward.sv
rtl/nn_update.sv
rtl/nn_top.sv
sim/tb_clock_gen.sv
sim/tb_nn.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then judge the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_nn -f all.f -o tb_nn_sim \
	&& ./obj_dir/tb_nn_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; } \
	|| grep -q "=== PASS ===" sim.log \
	|| { echo "no result in log"; exit 1; }
echo "simulation passed"

/* sim/tb_nn.sv */
// Self-checking testbench for nn_top, fixed-seed random stimulus
// Data and targets within +-1.0, weights within +-0.5, so no sum wraps
// The target goes out with the last data beat; samples use minimum spacing
// Outputs are sampled on the falling edge, inputs change on the rising edge
`timescale 1ns/10ps

module tb_nn;
	import nn_pkg::*;

	localparam int LR_SHIFT = 6;
	localparam int TIMEOUT  = 40;
	// Target beat to out_valid, in cycles
	localparam int LATENCY  = 5;
	// 1.0 and 0.5 in Q7.8
	localparam int DATA_LIM = 256;
	localparam int W_LIM    = 128;

	logic clk;
	logic rst_n;
	logic in_valid_d;
	logic in_valid_t;
	logic in_valid_w1;
	logic in_valid_w2;
	fx_t  data_point;
	fx_t  target;
	fx_t  weight1;
	fx_t  weight2;
	logic out_valid;
	fx_t  out;

	int seed      = 32'h1e61_f241;
	int n_pass    = 0;
	int n_fail    = 0;
	int idle_errs = 0;
	bit aborted   = 1'b0;

	// Reference model state
	fx_t m_w1 [N_W1];
	fx_t m_w2 [N_HID];
	fx_t m_x [N_IN];
	fx_t m_pre [N_HID];
	fx_t m_act [N_HID];
	fx_t m_y;
	fx_t last_out;

	tb_clock_gen u_clk (
		.clk  (clk),
		.rst_n(rst_n)
	);

	nn_top #(
		.LR_SHIFT(LR_SHIFT)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_d (in_valid_d),
		.in_valid_t (in_valid_t),
		.in_valid_w1(in_valid_w1),
		.in_valid_w2(in_valid_w2),
		.data_point (data_point),
		.target     (target),
		.weight1    (weight1),
		.weight2    (weight2),
		.out_valid  (out_valid),
		.out        (out)
	);

	// ==========================================================================
	// Random values and reference model
	// ==========================================================================
	// Uniform in -limit..limit
	function automatic fx_t rand_fx(input int limit);
		int r;
		r = $random(seed) % (limit + 1);
		return fx_t'(r);
	endfunction

	// Uniform in 1..limit
	function automatic fx_t rand_pos(input int limit);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return fx_t'(r % limit + 1);
	endfunction

	function automatic void random_weights();
		for (int k = 0; k < N_W1; k++)
			m_w1[k] = rand_fx(W_LIM);
		for (int j = 0; j < N_HID; j++)
			m_w2[j] = rand_fx(W_LIM);
	endfunction

	function automatic void random_data();
		for (int i = 0; i < N_IN; i++)
			m_x[i] = rand_fx(DATA_LIM);
	endfunction

	// Product scaled by 2**-8 with floor division, low 16 bits kept
	function automatic fx_t mul_floor(input fx_t a, input fx_t b);
		int p;
		int r;
		p = int'(a) * int'(b);
		r = p % 256;
		if (r < 0)
			r = r + 256;
		return fx_t'((p - r) / 256);
	endfunction

	// Hidden layer with ReLU, then the linear output; sums wrap at 16 bits
	function automatic void model_forward();
		fx_t acc;
		for (int j = 0; j < N_HID; j++)
		begin
			acc = '0;
			for (int i = 0; i < N_IN; i++)
				acc = acc + mul_floor(m_x[i], m_w1[j * N_IN + i]);
			m_pre[j] = acc;
			m_act[j] = (acc < 0) ? '0 : acc;
		end
		m_y = '0;
		for (int j = 0; j < N_HID; j++)
			m_y = m_y + mul_floor(m_w2[j], m_act[j]);
	endfunction

	// One gradient step; hidden deltas see the old output weights
	function automatic void model_update(input fx_t t);
		fx_t d2;
		fx_t d1 [N_HID];
		fx_t sc;
		d2 = m_y - t;
		for (int j = 0; j < N_HID; j++)
			d1[j] = (m_pre[j] < 0) ? '0 : mul_floor(m_w2[j], d2);
		for (int j = 0; j < N_HID; j++)
		begin
			sc       = m_act[j] >>> LR_SHIFT;
			m_w2[j]  = m_w2[j] - mul_floor(sc, d2);
		end
		for (int j = 0; j < N_HID; j++)
		begin
			for (int i = 0; i < N_IN; i++)
			begin
				sc = m_x[i] >>> LR_SHIFT;
				m_w1[j * N_IN + i] = m_w1[j * N_IN + i] - mul_floor(sc, d1[j]);
			end
		end
	endfunction

	function automatic void report_test(input string name, input bit good);
		if (good)
		begin
			n_pass++;
			$display("test %s: ok", name);
		end
		else
		begin
			n_fail++;
			$display("test %s: FAILED", name);
		end
	endfunction

	// ==========================================================================
	// Stimulus
	// ==========================================================================
	// Twelve layer-1 beats, then three layer-2 beats straight after
	task automatic send_weights();
		for (int k = 0; k < N_W1; k++)
		begin
			@(posedge clk);
			in_valid_w1 <= 1'b1;
			weight1     <= m_w1[k];
		end
		for (int j = 0; j < N_HID; j++)
		begin
			@(posedge clk);
			in_valid_w1 <= 1'b0;
			in_valid_w2 <= 1'b1;
			weight2     <= m_w2[j];
		end
		@(posedge clk);
		in_valid_w2 <= 1'b0;
	endtask

	// Four data beats, target on the last one
	task automatic send_sample(input fx_t t);
		for (int i = 0; i < N_IN; i++)
		begin
			@(posedge clk);
			in_valid_d <= 1'b1;
			data_point <= m_x[i];
			if (i == N_IN - 1)
			begin
				in_valid_t <= 1'b1;
				target     <= t;
			end
		end
		@(posedge clk);
		in_valid_d <= 1'b0;
		in_valid_t <= 1'b0;
	endtask

	// Starts one cycle after the target beat, counts cycles up to out_valid
	task automatic wait_prediction(output int lat, output fx_t val, output bit seen);
		lat  = 1;
		seen = 1'b0;
		val  = '0;
		while (!seen && lat <= TIMEOUT)
		begin
			@(negedge clk);
			if (out_valid)
			begin
				seen = 1'b1;
				val  = out;
			end
			else
			begin
				@(posedge clk);
				lat++;
			end
		end
	endtask

	// Full sample: drive, check latency and value, step the model
	task automatic run_sample(input fx_t t, output bit ok);
		int  lat;
		fx_t val;
		bit  seen;
		ok = 1'b0;
		if (!aborted)
		begin
			model_forward();
			send_sample(t);
			wait_prediction(lat, val, seen);
			if (!seen)
			begin
				$display("timeout: no out_valid within %0d cycles of the target beat", TIMEOUT);
				aborted = 1'b1;
			end
			else
			begin
				ok       = 1'b1;
				last_out = val;
				assert (lat == LATENCY)
				else
				begin
					$display("** Error at %0d ns: latency %0d, expected %0d", $time, lat, LATENCY);
					ok = 1'b0;
				end
				assert (val == m_y)
				else
				begin
					$display("** Error at %0d ns: out %0d, expected %0d", $time, val, m_y);
					ok = 1'b0;
				end
				model_update(t);
				// Next beat lands ten cycles after the target beat
				repeat (4)
					@(posedge clk);
			end
		end
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================
	task automatic reset_test();
		int cyc;
		bit good;
		cyc  = 0;
		good = 1'b1;
		while (!rst_n && cyc < TIMEOUT)
		begin
			@(posedge clk);
			cyc++;
		end
		if (!rst_n)
		begin
			$display("timeout: reset still asserted after %0d cycles", TIMEOUT);
			aborted = 1'b1;
			good    = 1'b0;
		end
		else
		begin
			for (int i = 0; i < 20; i++)
			begin
				@(negedge clk);
				assert (!out_valid && out == '0)
				else
				begin
					$display("** Error at %0d ns: out_valid %0b out %0d after reset",
						$time, out_valid, out);
					good = 1'b0;
				end
			end
		end
		report_test("1 idle after reset", good);
	endtask

	task automatic single_sample_test();
		bit good;
		random_weights();
		send_weights();
		random_data();
		run_sample(rand_fx(DATA_LIM), good);
		report_test("2 weight load and one sample", good);
	endtask

	// No reload, so every prediction depends on the previous updates
	task automatic back_to_back_test();
		bit good;
		bit ok;
		good = 1'b1;
		for (int n = 0; n < 10; n++)
		begin
			random_data();
			run_sample(rand_fx(DATA_LIM), ok);
			good = good & ok;
		end
		report_test("3 ten samples back to back", good);
	endtask

	// Positive layer-1 weights and negative inputs turn every neuron off
	task automatic dead_neuron_test();
		bit good;
		bit ok;
		for (int k = 0; k < N_W1; k++)
			m_w1[k] = rand_pos(W_LIM);
		for (int j = 0; j < N_HID; j++)
			m_w2[j] = rand_fx(W_LIM);
		send_weights();
		for (int i = 0; i < N_IN; i++)
			m_x[i] = -rand_pos(DATA_LIM);
		run_sample(rand_fx(DATA_LIM), good);
		if (good)
		begin
			assert (last_out == '0)
			else
			begin
				$display("** Error at %0d ns: out %0d with all neurons off", $time, last_out);
				good = 1'b0;
			end
		end
		// Weights left behind show up in the next prediction
		random_data();
		run_sample(rand_fx(DATA_LIM), ok);
		report_test("4 all hidden neurons off", good & ok);
	endtask

	task automatic reload_test();
		bit good;
		bit ok;
		good = 1'b1;
		for (int n = 0; n < 2; n++)
		begin
			random_data();
			run_sample(rand_fx(DATA_LIM), ok);
			good = good & ok;
		end
		random_weights();
		send_weights();
		random_data();
		run_sample(rand_fx(DATA_LIM), ok);
		report_test("5 reload mid-sequence", good & ok);
	endtask

	// out must read zero whenever it is not valid
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			assert (out_valid || out == '0)
			else
			begin
				$display("** Error at %0d ns: out %0d while out_valid is low", $time, out);
				idle_errs++;
			end
		end
	end

	initial
	begin
		in_valid_d  = 1'b0;
		in_valid_t  = 1'b0;
		in_valid_w1 = 1'b0;
		in_valid_w2 = 1'b0;
		data_point  = '0;
		target      = '0;
		weight1     = '0;
		weight2     = '0;
		reset_test();
		single_sample_test();
		back_to_back_test();
		dead_neuron_test();
		reload_test();
		report_test("6 out zero while invalid", idle_errs == 0 && !aborted);
		$display("tests passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0 && !aborted)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* sim/tb_clock_gen.sv */
// Free-running 40 ns clock for the testbench
// Reset is held low for the first 16 rising edges and leaves on an edge
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_NS      = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_NS) clk = ~clk;
	end

	// Active-low reset, released with the DUT inputs' timing
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* rtl/nn_top.sv */
// Four-input, three-hidden, one-output network with online training
// One sample at a time; next beat no earlier than ten cycles after target
// Weight loads only while idle, and they overwrite any learned values
`timescale 1ns/10ps

module nn_top #(
	parameter int LR_SHIFT = 6
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_valid_d,
	input  logic          in_valid_t,
	input  logic          in_valid_w1,
	input  logic          in_valid_w2,
	input  nn_pkg::fx_t   data_point,
	input  nn_pkg::fx_t   target,
	input  nn_pkg::fx_t   weight1,
	input  nn_pkg::fx_t   weight2,
	output logic          out_valid,
	output nn_pkg::fx_t   out
);
	import nn_pkg::*;

	// Collector outputs
	in_vec_t          sample;
	fx_t              smp_target;
	logic             go;
	logic             wr_en;
	logic             wr_layer2;
	logic [IDX_W-1:0] wr_idx;
	fx_t              wr_data;

	// Weight bank outputs
	w1_vec_t w1;
	w2_vec_t w2;

	// Forward results for the backward pass
	hid_vec_t hid_pre;
	hid_vec_t hid_act;
	fx_t      y_out;

	// Update results
	logic    upd_en;
	w1_vec_t w1_corr;
	w2_vec_t w2_corr;

	nn_sample_collector u_collector (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_d (in_valid_d),
		.in_valid_t (in_valid_t),
		.in_valid_w1(in_valid_w1),
		.in_valid_w2(in_valid_w2),
		.data_point (data_point),
		.target_in  (target),
		.weight1    (weight1),
		.weight2    (weight2),
		.sample     (sample),
		.target     (smp_target),
		.go         (go),
		.wr_en      (wr_en),
		.wr_layer2  (wr_layer2),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data)
	);

	nn_weight_bank u_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_layer2(wr_layer2),
		.wr_idx   (wr_idx),
		.wr_data  (wr_data),
		.upd_en   (upd_en),
		.w1_corr  (w1_corr),
		.w2_corr  (w2_corr),
		.w1       (w1),
		.w2       (w2)
	);

	nn_forward u_fwd (
		.clk      (clk),
		.rst_n    (rst_n),
		.go       (go),
		.sample   (sample),
		.w1       (w1),
		.w2       (w2),
		.hid_pre  (hid_pre),
		.hid_act  (hid_act),
		.y_out    (y_out),
		.out_valid(out_valid),
		.out      (out)
	);

	// The output valid pulse doubles as the start of the backward pass
	nn_update #(
		.LR_SHIFT(LR_SHIFT)
	) u_upd (
		.clk     (clk),
		.rst_n   (rst_n),
		.fwd_done(out_valid),
		.sample  (sample),
		.target  (smp_target),
		.y_out   (y_out),
		.hid_pre (hid_pre),
		.hid_act (hid_act),
		.w2      (w2),
		.upd_en  (upd_en),
		.w1_corr (w1_corr),
		.w2_corr (w2_corr)
	);

endmodule

/* rtl/nn_update.sv */
// Backward pass, started by the forward done pulse
// Learning rate is 2**-LR_SHIFT, applied as an arithmetic shift
// Uses the old w2 for the hidden deltas; corrections are held in CORR
// Sample, target and hidden values must not change until CORR
`timescale 1ns/10ps

module nn_update #(
	parameter int LR_SHIFT = 6
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fwd_done,
	input  nn_pkg::in_vec_t      sample,
	input  nn_pkg::fx_t          target,
	input  nn_pkg::fx_t          y_out,
	input  nn_pkg::hid_vec_t     hid_pre,
	input  nn_pkg::hid_vec_t     hid_act,
	input  nn_pkg::w2_vec_t      w2,
	output logic                 upd_en,
	output nn_pkg::w1_vec_t      w1_corr,
	output nn_pkg::w2_vec_t      w2_corr
);
	import nn_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		DELTA_OUT,
		DELTA_HID,
		CORR
	} upd_state_t;

	upd_state_t state;

	fx_t      delta2;
	hid_vec_t delta1;
	// Inputs and activations already scaled by the learning rate
	in_vec_t  sc_in;
	hid_vec_t sc_act;

	// ==========================================================================
	// Sequencer
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
		begin
			case (state)
				IDLE:
				begin
					if (fwd_done)
						state <= DELTA_OUT;
				end
				DELTA_OUT: state <= DELTA_HID;
				DELTA_HID: state <= CORR;
				CORR:      state <= IDLE;
				default:   state <= IDLE;
			endcase
		end
	end

	// Bank applies the corrections at the end of CORR
	assign upd_en = (state == CORR);

	// ==========================================================================
	// Deltas and corrections
	// ==========================================================================
	// Output error, captured with the prediction
	always_ff @(posedge clk)
	begin
		if (state == IDLE && fwd_done)
			delta2 <= y_out - target;
	end

	always_ff @(posedge clk)
	begin
		if (state == DELTA_OUT)
		begin
			// Back through w2, blocked where the neuron was off
			for (int j = 0; j < N_HID; j++)
			begin
				delta1[j] <= hid_pre[j][FX_W-1] ? '0 : fx_mul(w2[j], delta2);
				sc_act[j] <= hid_act[j] >>> LR_SHIFT;
			end
			for (int i = 0; i < N_IN; i++)
				sc_in[i] <= sample[i] >>> LR_SHIFT;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == DELTA_HID)
		begin
			for (int j = 0; j < N_HID; j++)
				w2_corr[j] <= fx_mul(sc_act[j], delta2);
			// Weight j*N_IN + i pairs input i with neuron j
			for (int k = 0; k < N_W1; k++)
				w1_corr[k] <= fx_mul(sc_in[k % N_IN], delta1[k / N_IN]);
		end
	end

endmodule

/* rtl/nn_forward.sv */
// Four register stages after go, prediction on out at go + 4
// out is zero outside its single valid cycle, y_out keeps the value
// Hidden pre-activations and ReLU outputs stay until the next go
`timescale 1ns/10ps

module nn_forward (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 go,
	input  nn_pkg::in_vec_t      sample,
	input  nn_pkg::w1_vec_t      w1,
	input  nn_pkg::w2_vec_t      w2,
	output nn_pkg::hid_vec_t     hid_pre,
	output nn_pkg::hid_vec_t     hid_act,
	output nn_pkg::fx_t          y_out,
	output logic                 out_valid,
	output nn_pkg::fx_t          out
);
	import nn_pkg::*;

	// Stage enables after go
	logic [2:0] stg;

	w1_vec_t  prod1;
	hid_vec_t hid_sum;
	hid_vec_t prod2;
	fx_t      y_sum;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stg <= '0;
		else
			stg <= {stg[1:0], go};
	end

	// ==========================================================================
	// Hidden layer
	// ==========================================================================
	// Input products, one per layer-1 weight
	always_ff @(posedge clk)
	begin
		if (go)
		begin
			for (int k = 0; k < N_W1; k++)
				prod1[k] <= fx_mul(sample[k % N_IN], w1[k]);
		end
	end

	// Per-neuron sum of four products, wrapping
	always_comb
	begin
		for (int j = 0; j < N_HID; j++)
		begin
			hid_sum[j] = '0;
			for (int i = 0; i < N_IN; i++)
				hid_sum[j] = hid_sum[j] + prod1[j * N_IN + i];
		end
	end

	// Pre-activation kept for the backward pass
	always_ff @(posedge clk)
	begin
		if (stg[0])
		begin
			hid_pre <= hid_sum;
			// ReLU clamps negative sums
			for (int j = 0; j < N_HID; j++)
				hid_act[j] <= hid_sum[j][FX_W-1] ? '0 : hid_sum[j];
		end
	end

	// ==========================================================================
	// Output neuron
	// ==========================================================================
	always_ff @(posedge clk)
	begin
		if (stg[1])
		begin
			for (int j = 0; j < N_HID; j++)
				prod2[j] <= fx_mul(w2[j], hid_act[j]);
		end
	end

	// Linear output, no activation
	always_comb
	begin
		y_sum = '0;
		for (int j = 0; j < N_HID; j++)
			y_sum = y_sum + prod2[j];
	end

	always_ff @(posedge clk)
	begin
		if (stg[2])
			y_out <= y_sum;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out       <= '0;
		end
		else
		begin
			out_valid <= stg[2];
			out       <= stg[2] ? y_sum : '0;
		end
	end

	// One prediction per sample
	a_single_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else $error("out_valid held longer than one cycle");

endmodule

/* rtl/nn_weight_bank.sv */
// All fifteen weights as registers, cleared to zero by reset
// A load writes one word; an update subtracts every correction at once
// Subtraction wraps at 16 bits
`timescale 1ns/10ps

module nn_weight_bank (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        wr_en,
	input  logic                        wr_layer2,
	input  logic [nn_pkg::IDX_W-1:0]    wr_idx,
	input  nn_pkg::fx_t                 wr_data,
	input  logic                        upd_en,
	input  nn_pkg::w1_vec_t             w1_corr,
	input  nn_pkg::w2_vec_t             w2_corr,
	output nn_pkg::w1_vec_t             w1,
	output nn_pkg::w2_vec_t             w2
);
	import nn_pkg::*;

	// ==========================================================================
	// Layer-1 weights
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			w1 <= '0;
		else if (wr_en)
		begin
			// Single word from the serial load
			for (int k = 0; k < N_W1; k++)
			begin
				if (!wr_layer2 && wr_idx == IDX_W'(k))
					w1[k] <= wr_data;
			end
		end
		else if (upd_en)
		begin
			// Gradient step on every weight
			for (int k = 0; k < N_W1; k++)
				w1[k] <= w1[k] - w1_corr[k];
		end
	end

	// ==========================================================================
	// Layer-2 weights
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			w2 <= '0;
		else if (wr_en)
		begin
			for (int j = 0; j < N_HID; j++)
			begin
				if (wr_layer2 && wr_idx == IDX_W'(j))
					w2[j] <= wr_data;
			end
		end
		else if (upd_en)
		begin
			for (int j = 0; j < N_HID; j++)
				w2[j] <= w2[j] - w2_corr[j];
		end
	end

	// Loads happen only while idle, so they never meet an update
	a_wr_upd_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_en && upd_en))
		else $error("weight load collides with update");

endmodule

/* rtl/nn_sample_collector.sv */
// Beat counters restart whenever their strobe drops
// Data is four beats; the target beat is no earlier than the last one
// After the target beat all strobes must stay low for nine cycles
// Weight beats leave as write requests one cycle later
`timescale 1ns/10ps

module nn_sample_collector (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        in_valid_d,
	input  logic                        in_valid_t,
	input  logic                        in_valid_w1,
	input  logic                        in_valid_w2,
	input  nn_pkg::fx_t                 data_point,
	input  nn_pkg::fx_t                 target_in,
	input  nn_pkg::fx_t                 weight1,
	input  nn_pkg::fx_t                 weight2,
	output nn_pkg::in_vec_t             sample,
	output nn_pkg::fx_t                 target,
	output logic                        go,
	output logic                        wr_en,
	output logic                        wr_layer2,
	output logic [nn_pkg::IDX_W-1:0]    wr_idx,
	output nn_pkg::fx_t                 wr_data
);
	import nn_pkg::*;

	localparam int D_CNT_W  = $clog2(N_IN);
	localparam int W2_CNT_W = $clog2(N_HID);
	// Forward pass plus update, target beat to first free cycle
	localparam logic [3:0] BUSY_CYCLES = 4'd9;

	logic [D_CNT_W-1:0]  d_cnt;
	logic [IDX_W-1:0]    w1_cnt;
	logic [W2_CNT_W-1:0] w2_cnt;
	logic [3:0]          busy_cnt;

	// ==========================================================================
	// Beat counters
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			d_cnt  <= '0;
			w1_cnt <= '0;
			w2_cnt <= '0;
		end
		else
		begin
			d_cnt  <= in_valid_d  ? d_cnt + D_CNT_W'(1)   : '0;
			w1_cnt <= in_valid_w1 ? w1_cnt + IDX_W'(1)    : '0;
			w2_cnt <= in_valid_w2 ? w2_cnt + W2_CNT_W'(1) : '0;
		end
	end

	// Sample storage, held until the next sample arrives
	always_ff @(posedge clk)
	begin
		if (in_valid_d)
			sample[d_cnt] <= data_point;
		if (in_valid_t)
			target <= target_in;
	end

	// Loaded on the target beat, counts the busy window down
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			busy_cnt <= '0;
		else if (in_valid_t)
			busy_cnt <= BUSY_CYCLES;
		else if (busy_cnt != '0)
			busy_cnt <= busy_cnt - 4'd1;
	end

	// First cycle of the window is the start pulse
	assign go = (busy_cnt == BUSY_CYCLES);

	// ==========================================================================
	// Weight write requests
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_en     <= 1'b0;
			wr_layer2 <= 1'b0;
		end
		else
		begin
			wr_en     <= in_valid_w1 | in_valid_w2;
			wr_layer2 <= in_valid_w2;
		end
	end

	always_ff @(posedge clk)
	begin
		wr_idx  <= in_valid_w2 ? IDX_W'(w2_cnt) : w1_cnt;
		wr_data <= in_valid_w2 ? weight2 : weight1;
	end

	// Target may share a cycle with the last data beat, nothing else may
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({in_valid_d | in_valid_t, in_valid_w1, in_valid_w2}))
		else $error("input streams overlap");

	// No new beat while the forward pass and update are still running
	a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		(busy_cnt != '0) |-> !(in_valid_d | in_valid_t | in_valid_w1 | in_valid_w2))
		else $error("input beat inside the busy window");

endmodule

/* rtl/nn_pkg.sv */
// Signed Q7.8 fixed point for the whole network, 16-bit words
// Additions and subtractions wrap at 16 bits, no saturation anywhere
// fx_mul truncates, so products round toward minus infinity
// Layer-1 weight j*N_IN + i connects input i to hidden neuron j
package nn_pkg;

	// ==========================================================================
	// Word formats
	// ==========================================================================
	localparam int FX_W      = 16;
	localparam int FX_FRAC   = 8;
	localparam int FX_WIDE_W = 2 * FX_W;

	// Network sizes
	localparam int N_IN  = 4;
	localparam int N_HID = 3;
	localparam int N_W1  = N_IN * N_HID;

	// Wide enough to address any layer-1 weight
	localparam int IDX_W = $clog2(N_W1);

	typedef logic signed [FX_W-1:0]      fx_t;
	typedef logic signed [FX_WIDE_W-1:0] fx_wide_t;

	// Element 0 sits in the low bits
	typedef fx_t [N_W1-1:0]  w1_vec_t;
	typedef fx_t [N_HID-1:0] w2_vec_t;
	typedef fx_t [N_HID-1:0] hid_vec_t;
	typedef fx_t [N_IN-1:0]  in_vec_t;

	// ==========================================================================
	// Fixed-point multiply
	// ==========================================================================
	// Full 32-bit product, then drop the extra fraction bits
	function automatic fx_t fx_mul(input fx_t a, input fx_t b);
		fx_wide_t prod;
		prod = fx_wide_t'(a) * fx_wide_t'(b);
		// Arithmetic shift keeps the sign
		prod = prod >>> FX_FRAC;
		return prod[FX_W-1:0];
	endfunction

endpackage
